// ==== Makefile ====
# Verilator build and run for the uTLB PLRU unit

VERILATOR ?= verilator
TOP       ?= tb_utlb_plru
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TEST OK

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
+incdir+include
hdl/lru_geom_pkg.sv
hdl/lru_op_pkg.sv
hdl/utlb_lru_req_decode.sv
hdl/utlb_plru_tree.sv
hdl/utlb_refill_sel.sv
hdl/utlb_plru_top.sv
verif/tb_utlb_plru.sv

// ==== hdl/lru_geom_pkg.sv ====
`include "lru_config.svh"

package lru_geom_pkg;

  //============================================================
  // Entry and tree shapes
  //============================================================

  // Entry number
  typedef logic [`LRU_IDX_W-1:0] entry_idx_t;

  // One bit per entry, for hit, valid and one-hot ref vectors
  typedef logic [`LRU_ENTRY_NUM-1:0] entry_vec_t;

  // Node bits in heap order
  // children of node n sit at 2n+1 (left) and 2n+2 (right)
  typedef logic [`LRU_TREE_W-1:0] plru_tree_t;

endpackage

// ==== hdl/lru_op_pkg.sv ====
package lru_op_pkg;

  //============================================================
  // Tree update requests
  //============================================================

  // One update per cycle at most
  typedef enum logic [1:0]
  {
    LRU_UPDT_NONE   = 2'd0,
    // Read hit on an existing entry
    LRU_UPDT_READ   = 2'd1,
    // Entry rewritten by a refill
    LRU_UPDT_REFILL = 2'd2
  } lru_updt_op_t;

endpackage

// ==== hdl/utlb_lru_req_decode.sv ====
`timescale 1ns/1ps
`include "lru_config.svh"

module utlb_lru_req_decode
(
  input  lru_geom_pkg::entry_vec_t   i_read_hit,
  input  logic                       i_read_hit_vld,
  input  logic                       i_refill_vld,
  input  lru_geom_pkg::entry_idx_t   i_refill_idx,
  output lru_op_pkg::lru_updt_op_t   o_updt_op,
  output lru_geom_pkg::entry_idx_t   o_updt_idx
);

  import lru_geom_pkg::*;
  import lru_op_pkg::*;

  entry_idx_t hit_idx;
  logic       hit_any;

  //============================================================
  // Hit vector encode
  //============================================================

  // Lowest set bit wins, scan runs downward so it lands last
  always_comb
  begin
    integer i;
    hit_idx = '0;
    for (i = `LRU_ENTRY_NUM - 1; i >= 0; i--)
    begin
      if (i_read_hit[i])
      begin
        hit_idx = entry_idx_t'(i);
      end
    end
  end

  assign hit_any = |i_read_hit;

  //============================================================
  // Opcode select
  //============================================================

  // Read hit beats a refill write in the same cycle
  always_comb
  begin
    if (i_read_hit_vld && hit_any)
    begin
      o_updt_op  = LRU_UPDT_READ;
      o_updt_idx = hit_idx;
    end
    else if (i_refill_vld)
    begin
      o_updt_op  = LRU_UPDT_REFILL;
      o_updt_idx = i_refill_idx;
    end
    else
    begin
      o_updt_op  = LRU_UPDT_NONE;
      o_updt_idx = i_refill_idx;
    end
  end

endmodule

// ==== hdl/utlb_plru_top.sv ====
`timescale 1ns/1ps

module utlb_plru_top
(
  input  logic                       lru_clk,
  input  logic                       cpurst_b,
  input  lru_geom_pkg::entry_vec_t   i_entry_vld,
  input  lru_geom_pkg::entry_vec_t   i_read_hit,
  input  logic                       i_read_hit_vld,
  input  logic                       i_refill_on,
  input  logic                       i_refill_vld,
  output lru_geom_pkg::entry_vec_t   o_ref_num
);

  import lru_geom_pkg::*;
  import lru_op_pkg::*;

  lru_updt_op_t updt_op;
  entry_idx_t   updt_idx;
  entry_idx_t   victim_idx;
  entry_idx_t   refill_idx;

  //============================================================
  // Request decode
  //============================================================

  utlb_lru_req_decode u_req_decode
  (
    .i_read_hit     (i_read_hit),
    .i_read_hit_vld (i_read_hit_vld),
    .i_refill_vld   (i_refill_vld),
    .i_refill_idx   (refill_idx),
    .o_updt_op      (updt_op),
    .o_updt_idx     (updt_idx)
  );

  //============================================================
  // Tree state
  //============================================================

  utlb_plru_tree u_plru_tree
  (
    .lru_clk      (lru_clk),
    .cpurst_b     (cpurst_b),
    .i_updt_op    (updt_op),
    .i_updt_idx   (updt_idx),
    .o_victim_idx (victim_idx)
  );

  //============================================================
  // Refill selection
  //============================================================

  utlb_refill_sel u_refill_sel
  (
    .lru_clk      (lru_clk),
    .cpurst_b     (cpurst_b),
    .i_entry_vld  (i_entry_vld),
    .i_victim_idx (victim_idx),
    .i_refill_on  (i_refill_on),
    .o_refill_idx (refill_idx),
    .o_ref_num    (o_ref_num)
  );

endmodule

// ==== hdl/utlb_plru_tree.sv ====
`timescale 1ns/1ps
`include "lru_config.svh"

module utlb_plru_tree
(
  input  logic                       lru_clk,
  input  logic                       cpurst_b,
  input  lru_op_pkg::lru_updt_op_t   i_updt_op,
  input  lru_geom_pkg::entry_idx_t   i_updt_idx,
  output lru_geom_pkg::entry_idx_t   o_victim_idx
);

  import lru_geom_pkg::*;
  import lru_op_pkg::*;

  //                    node 0
  //                   /      \
  //              node 1      node 2
  //             /    \       /    \
  //            3      4     5      6
  //           ...  five levels  ...
  //          15 .......................  30
  //
  // Bit 1 means the right subtree is the older one

  plru_tree_t tree_q;
  plru_tree_t tree_nxt;
  entry_idx_t victim_idx;

  //============================================================
  // Path update
  //============================================================

  // Each node on the accessed path points away from the entry
  always_comb
  begin
    integer d;
    integer node;
    logic   go_right;
    tree_nxt = tree_q;
    node     = 0;
    for (d = 0; d < `LRU_IDX_W; d++)
    begin
      go_right       = i_updt_idx[`LRU_IDX_W-1-d];
      tree_nxt[node] = ~go_right;
      node           = 2 * node + 1 + int'(go_right);
    end
  end

  always_ff @(posedge lru_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      tree_q <= '0;
    end
    else if (i_updt_op != LRU_UPDT_NONE)
    begin
      tree_q <= tree_nxt;
    end
  end

  //============================================================
  // Victim walk
  //============================================================

  // Follow the stored bits from the root, MSB of the index first
  always_comb
  begin
    integer d;
    integer node;
    logic   go_right;
    victim_idx = '0;
    node       = 0;
    for (d = 0; d < `LRU_IDX_W; d++)
    begin
      go_right                         = tree_q[node];
      victim_idx[`LRU_IDX_W-1-d]       = go_right;
      node                             = 2 * node + 1 + int'(go_right);
    end
  end

  assign o_victim_idx = victim_idx;

endmodule

// ==== hdl/utlb_refill_sel.sv ====
`timescale 1ns/1ps
`include "lru_config.svh"

module utlb_refill_sel
(
  input  logic                       lru_clk,
  input  logic                       cpurst_b,
  input  lru_geom_pkg::entry_vec_t   i_entry_vld,
  input  lru_geom_pkg::entry_idx_t   i_victim_idx,
  input  logic                       i_refill_on,
  output lru_geom_pkg::entry_idx_t   o_refill_idx,
  output lru_geom_pkg::entry_vec_t   o_ref_num
);

  import lru_geom_pkg::*;

  entry_idx_t free_idx;
  entry_idx_t write_idx;
  entry_idx_t refill_idx_q;

  //============================================================
  // Refill entry choice
  //============================================================

  // Lowest invalid entry first
  always_comb
  begin
    integer i;
    free_idx = '0;
    for (i = `LRU_ENTRY_NUM - 1; i >= 0; i--)
    begin
      if (!i_entry_vld[i])
      begin
        free_idx = entry_idx_t'(i);
      end
    end
  end

  // Full table falls back to the tree victim
  assign write_idx = (&i_entry_vld) ? i_victim_idx : free_idx;

  always_ff @(posedge lru_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      refill_idx_q <= '0;
    end
    else if (i_refill_on)
    begin
      refill_idx_q <= write_idx;
    end
  end

  assign o_refill_idx = refill_idx_q;

  // One-hot form for the uTLB write enables
  assign o_ref_num = entry_vec_t'(1) << refill_idx_q;

endmodule

// ==== include/lru_config.svh ====
`ifndef LRU_CONFIG_SVH
`define LRU_CONFIG_SVH

//============================================================
// uTLB replacement geometry
//============================================================

// Entries in the micro-TLB
`define LRU_ENTRY_NUM 32

// Bits needed to name one entry
`define LRU_IDX_W 5

// Internal nodes of the binary tree, one less than entries
`define LRU_TREE_W 31

`endif

// ==== verif/tb_utlb_plru.sv ====
`timescale 1ns/1ps
`include "lru_config.svh"

module tb_utlb_plru;

  import lru_geom_pkg::*;

  localparam int CLK_HALF_NS    = 20;
  localparam int RST_CYCLES     = 10;
  localparam int N_FREE         = 20;
  localparam int N_HIT_ROUNDS   = 10;
  localparam int HITS_PER_ROUND = 30;
  localparam int N_WRITE        = 10;
  localparam int N_BOTH         = 10;
  localparam int N_RANDOM       = 2000;
  localparam int TEST_CYCLES    = RST_CYCLES + 4 + 2 * N_FREE
                                  + N_HIT_ROUNDS * (HITS_PER_ROUND + 2)
                                  + 3 * N_WRITE + 2 * N_BOTH + N_RANDOM + 2;
  localparam int TIMEOUT_NS     = (TEST_CYCLES + 100) * 2 * CLK_HALF_NS;

  logic       lru_clk;
  logic       cpurst_b;
  entry_vec_t i_entry_vld;
  entry_vec_t i_read_hit;
  logic       i_read_hit_vld;
  logic       i_refill_on;
  logic       i_refill_vld;
  entry_vec_t o_ref_num;

  plru_tree_t  model_tree;
  entry_idx_t  model_refill_idx;
  logic [31:0] lcg_state;
  int          check_cnt;

  utlb_plru_top dut_i
  (
    .lru_clk        (lru_clk),
    .cpurst_b       (cpurst_b),
    .i_entry_vld    (i_entry_vld),
    .i_read_hit     (i_read_hit),
    .i_read_hit_vld (i_read_hit_vld),
    .i_refill_on    (i_refill_on),
    .i_refill_vld   (i_refill_vld),
    .o_ref_num      (o_ref_num)
  );

  always #(CLK_HALF_NS) lru_clk = ~lru_clk;

  //============================================================
  // Random source
  //============================================================

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Low LCG bits repeat too soon so only upper halves are used
  function automatic entry_vec_t random_vec();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};
  endfunction

  function automatic entry_idx_t pick_idx();
    logic [31:0] r;
    r = lcg_next();
    return r[27:23];
  endfunction

  //============================================================
  // Reference model
  //============================================================

  function automatic entry_vec_t onehot(input entry_idx_t idx);
    entry_vec_t v;
    v = '0;
    v[idx] = 1'b1;
    return v;
  endfunction

  // Position of the lowest set bit or -1 for an empty vector
  function automatic int lowest_set(input entry_vec_t vec);
    int i;
    for (i = 0; i < `LRU_ENTRY_NUM; i++)
    begin
      if (vec[i])
      begin
        return i;
      end
    end
    return -1;
  endfunction

  // Depth d node sits at 2^d - 1 plus the top d index bits
  function automatic plru_tree_t touch_path(input plru_tree_t tree, input entry_idx_t idx);
    plru_tree_t t;
    int         d;
    int         node;
    t = tree;
    for (d = 0; d < `LRU_IDX_W; d++)
    begin
      node    = (1 << d) - 1 + int'(idx >> (`LRU_IDX_W - d));
      t[node] = ~idx[`LRU_IDX_W-1-d];
    end
    return t;
  endfunction

  function automatic entry_idx_t find_victim(input plru_tree_t tree);
    entry_idx_t v;
    int         d;
    int         node;
    v = '0;
    for (d = 0; d < `LRU_IDX_W; d++)
    begin
      node                = (1 << d) - 1 + int'(v >> (`LRU_IDX_W - d));
      v[`LRU_IDX_W-1-d]   = tree[node];
    end
    return v;
  endfunction

  // One clock edge of the whole unit
  function automatic void step_model
  (
    input  plru_tree_t tree,
    input  entry_idx_t refill_idx,
    input  entry_vec_t vld,
    input  entry_vec_t hit,
    input  logic       hit_vld,
    input  logic       refill_on,
    input  logic       refill_vld,
    output plru_tree_t tree_next,
    output entry_idx_t refill_idx_next
  );
    int free_pos;
    int hit_pos;
    free_pos        = lowest_set(~vld);
    hit_pos         = lowest_set(hit);
    refill_idx_next = refill_idx;
    if (refill_on)
    begin
      if (free_pos < 0)
      begin
        refill_idx_next = find_victim(tree);
      end
      else
      begin
        refill_idx_next = entry_idx_t'(free_pos);
      end
    end
    tree_next = tree;
    if (hit_vld && hit_pos >= 0)
    begin
      tree_next = touch_path(tree, entry_idx_t'(hit_pos));
    end
    else if (refill_vld)
    begin
      tree_next = touch_path(tree, refill_idx);
    end
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp)
    begin
      $display("CHECK FAILED: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  //============================================================
  // Compare process
  //============================================================

  // Model steps on the edge and the output is compared mid-cycle
  initial
  begin
    plru_tree_t tree_n;
    entry_idx_t idx_n;
    forever
    begin
      @(posedge lru_clk);
      if (!cpurst_b)
      begin
        model_tree       = '0;
        model_refill_idx = '0;
      end
      else
      begin
        step_model(model_tree, model_refill_idx, i_entry_vld, i_read_hit, i_read_hit_vld,
                   i_refill_on, i_refill_vld, tree_n, idx_n);
        model_tree       = tree_n;
        model_refill_idx = idx_n;
      end
      @(negedge lru_clk);
      check_value("o_ref_num", o_ref_num, onehot(model_refill_idx));
    end
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  //============================================================
  // Stimulus
  //============================================================

  task automatic next_cycle();
    @(posedge lru_clk);
    #2;
  endtask

  initial
  begin
    entry_vec_t  vld;
    logic [31:0] r;
    lcg_state      = 32'h59c8;
    check_cnt      = 0;
    lru_clk        = 1'b0;
    cpurst_b       = 1'b0;
    i_entry_vld    = '0;
    i_read_hit     = '0;
    i_read_hit_vld = 1'b0;
    i_refill_on    = 1'b0;
    i_refill_vld   = 1'b0;
    repeat (RST_CYCLES) next_cycle();
    cpurst_b = 1'b1;
    @(negedge lru_clk);
    check_value("o_ref_num", o_ref_num, onehot(entry_idx_t'(0)));

    // Park the refill register on the top entry first
    next_cycle();
    i_entry_vld = ~onehot(entry_idx_t'(`LRU_ENTRY_NUM - 1));
    i_refill_on = 1'b1;
    next_cycle();

    // Full table on a fresh tree picks entry 0
    i_entry_vld = '1;
    next_cycle();
    i_refill_on = 1'b0;
    @(negedge lru_clk);
    check_value("o_ref_num", o_ref_num, onehot(entry_idx_t'(0)));

    // Lowest invalid entry
    repeat (N_FREE)
    begin
      vld              = random_vec();
      vld[pick_idx()]  = 1'b0;
      i_entry_vld      = vld;
      i_refill_on      = 1'b1;
      next_cycle();
      i_refill_on = 1'b0;
      @(negedge lru_clk);
      check_value("o_ref_num", o_ref_num, onehot(entry_idx_t'(lowest_set(~vld))));
      next_cycle();
    end

    // Read hits steer the victim
    i_entry_vld = '1;
    repeat (N_HIT_ROUNDS)
    begin
      repeat (HITS_PER_ROUND)
      begin
        i_read_hit_vld = 1'b1;
        i_read_hit     = onehot(pick_idx());
        next_cycle();
      end
      i_read_hit_vld = 1'b0;
      i_read_hit     = '0;
      i_refill_on    = 1'b1;
      next_cycle();
      i_refill_on = 1'b0;
      next_cycle();
    end

    // Refill writes touch the registered index
    repeat (N_WRITE)
    begin
      i_refill_on = 1'b1;
      next_cycle();
      i_refill_on  = 1'b0;
      i_refill_vld = 1'b1;
      next_cycle();
      i_refill_vld = 1'b0;
      next_cycle();
    end

    // Hit and refill write together
    repeat (N_BOTH)
    begin
      i_read_hit_vld = 1'b1;
      i_read_hit     = onehot(pick_idx());
      i_refill_vld   = 1'b1;
      next_cycle();
      i_read_hit_vld = 1'b0;
      i_read_hit     = '0;
      i_refill_vld   = 1'b0;
      i_refill_on    = 1'b1;
      next_cycle();
      i_refill_on = 1'b0;
    end

    // Random mix with a mostly full table
    repeat (N_RANDOM)
    begin
      r              = lcg_next();
      i_entry_vld    = (r[31:29] == 3'd0) ? random_vec() : '1;
      i_read_hit_vld = r[28];
      i_read_hit     = r[27] ? onehot(pick_idx()) : '0;
      i_refill_on    = r[26] & r[25];
      i_refill_vld   = r[24];
      next_cycle();
    end

    i_read_hit_vld = 1'b0;
    i_read_hit     = '0;
    i_refill_on    = 1'b0;
    i_refill_vld   = 1'b0;
    next_cycle();
    next_cycle();

    $display("Compared %0d values", check_cnt);
    $display("TEST OK");
    $finish;
  end

endmodule
